/* pov_pkg.sv */
/*
 * POV LED column engine, shared definitions
 * Widths, depths, SPI opcodes and FSM state types used by the
 * SPI receiver, the column buffer and the LED driver controller
 */
package pov_pkg;

    // LED driver bank geometry
    localparam int NUM_DRV    = 4;
    localparam int DRV_BITS   = 16;
    localparam int COL_W      = NUM_DRV * DRV_BITS;
    localparam int COL_BYTES  = COL_W / 8;
    localparam int NUM_COLS   = 8;

    // Column buffer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Counter widths
    localparam int COL_BYTE_W = $clog2(COL_BYTES);
    localparam int DRV_CNT_W  = $clog2(DRV_BITS);
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    // SPI command opcodes, first byte of a frame
    localparam logic [7:0] OP_WRITE_COL  = 8'h01;
    localparam logic [7:0] OP_SET_MASK   = 8'h02;
    localparam logic [7:0] OP_READ_DROPS = 8'h03;

    // Driver k word lives at bits k*DRV_BITS upward
    typedef logic [COL_W-1:0]    column_t;
    typedef logic [NUM_COLS-1:0] col_mask_t;
    typedef logic [7:0]          drop_cnt_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    // SPI frame decoder
    typedef enum logic [2:0] {
        IDLE_OP,
        COL_DATA,
        MASK_DATA,
        STATUS,
        IGNORE
    } rx_state_e;

    // Driver controller
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        LATCH
    } drv_state_e;

endpackage

/* col_if.sv */
/*
 * Column link
 * One column and its select mask, sent as a single-cycle valid
 * against credits that the receiver returns as one-cycle pulses
 */
`timescale 1ns/10ps

interface col_if;
    import pov_pkg::*;

    // Sender side
    logic      valid;
    column_t   data;
    col_mask_t mask;

    // Receiver side, one pulse per freed entry
    logic      credit;

    modport sender (
        output valid,
        output data,
        output mask,
        input  credit
    );

    modport receiver (
        input  valid,
        input  data,
        input  mask,
        output credit
    );

endinterface

/* spi_cmd_rx.sv */
/*
 * SPI command receiver
 * Mode 0 SPI slave, MSB first, pins synchronized to clk.
 * Decodes column writes, mask updates and drop count reads,
 * pushes columns downstream against credits and counts drops
 */
`timescale 1ns/10ps

module spi_cmd_rx (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  spi_cs_n,
    input  logic  spi_sclk,
    input  logic  spi_mosi,
    output logic  spi_miso,
    col_if.sender out
);
    import pov_pkg::*;

    // Two-flop synchronizers and edge detect
    logic [1:0] cs_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_idle;

    // Byte assembly
    logic [7:0] byte_sr;
    logic [2:0] bit_cnt;
    logic       byte_done;

    // Frame decode and payload
    rx_state_e             state;
    logic [COL_BYTE_W-1:0] byte_cnt;
    column_t               col_sr;
    col_mask_t             mask;
    logic                  push_req;
    logic                  take;

    // Flow control and status
    credit_t    credits;
    drop_cnt_t  drop_cnt;
    logic [7:0] miso_sr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs_sync   <= 2'b11;
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_sync <= {sclk_sync[0], spi_sclk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign cs_idle   = cs_sync[1];

    // MOSI sampled on rising SCLK, byte_done one cycle after the eighth bit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_sr   <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (cs_idle) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                byte_sr   <= {byte_sr[6:0], mosi_sync[1]};
                bit_cnt   <= bit_cnt + 3'd1;
                byte_done <= (bit_cnt == 3'd7);
            end
        end
    end

    // Frame decoder, CS high aborts whatever is in progress
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE_OP;
            byte_cnt <= '0;
            mask     <= '1;
            push_req <= 1'b0;
        end else begin
            push_req <= 1'b0;
            if (cs_idle) begin
                state    <= IDLE_OP;
                byte_cnt <= '0;
            end else if (byte_done) begin
                case (state)
                    IDLE_OP: begin
                        byte_cnt <= '0;
                        case (byte_sr)
                            OP_WRITE_COL:  state <= COL_DATA;
                            OP_SET_MASK:   state <= MASK_DATA;
                            OP_READ_DROPS: state <= STATUS;
                            default:       state <= IGNORE;
                        endcase
                    end
                    COL_DATA: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // Last payload byte completes the column
                        if (byte_cnt == COL_BYTE_W'(COL_BYTES - 1)) begin
                            push_req <= 1'b1;
                            state    <= IGNORE;
                        end
                    end
                    MASK_DATA: begin
                        mask  <= byte_sr;
                        state <= IGNORE;
                    end
                    default: state <= IGNORE;
                endcase
            end
        end
    end

    // First byte ends up in the top byte after COL_BYTES shifts
    always_ff @(posedge clk) begin
        if (byte_done && state == COL_DATA) begin
            col_sr <= {col_sr[COL_W-9:0], byte_sr};
        end
    end

    assign take = push_req && (credits != '0);

    // Push when a credit is held, otherwise drop and count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
            credits   <= credit_t'(FIFO_DEPTH);
            drop_cnt  <= '0;
        end else begin
            out.valid <= take;
            credits   <= credits + credit_t'(out.credit) - credit_t'(take);
            if (push_req && !take) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    assign out.data = col_sr;
    assign out.mask = mask;

    // Drop count snapshot at opcode end, shifted out on falling SCLK
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            miso_sr  <= '0;
            spi_miso <= 1'b0;
        end else if (cs_idle) begin
            spi_miso <= 1'b0;
        end else if (byte_done && state == IDLE_OP && byte_sr == OP_READ_DROPS) begin
            miso_sr <= drop_cnt;
        end else if (sclk_fall) begin
            spi_miso <= (state == STATUS) ? miso_sr[7] : 1'b0;
            miso_sr  <= {miso_sr[6:0], 1'b0};
        end
    end

    // Returned credits never exceed the buffer depth
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n) credits <= credit_t'(FIFO_DEPTH)
    ) else $error("producer credit overflow");

endmodule

/* column_fifo.sv */
/*
 * Column buffer
 * Circular buffer of column and mask entries between the SPI
 * receiver and the driver controller, credit fed on both sides
 */
`timescale 1ns/10ps

module column_fifo (
    input  logic    clk,
    input  logic    arst_n,
    col_if.receiver in,
    col_if.sender   out
);
    import pov_pkg::*;

    column_t               data_mem [FIFO_DEPTH];
    col_mask_t             mask_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    credit_t               count;
    // Consumer holds a single column
    logic                  dn_credit;

    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Head goes out as soon as the consumer has room
    assign out.valid = (count != '0) && dn_credit;
    assign out.data  = data_mem[rd_ptr];
    assign out.mask  = mask_mem[rd_ptr];

    // Forwarding an entry frees its slot
    assign in.credit = out.valid;

    always_ff @(posedge clk) begin
        if (in.valid) begin
            data_mem[wr_ptr] <= in.data;
            mask_mem[wr_ptr] <= in.mask;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            dn_credit <= 1'b1;
        end else begin
            if (in.valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (out.valid) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count     <= count + credit_t'(in.valid) - credit_t'(out.valid);
            // Returned credit may land in the same cycle as a send
            dn_credit <= (dn_credit & ~out.valid) | out.credit;
        end
    end

    // Producer credits must keep writes off a full buffer
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n) in.valid |-> count != credit_t'(FIFO_DEPTH)
    ) else $error("write into full column buffer");

endmodule

/* led_driver_ctrl.sv */
/*
 * LED driver controller
 * Shifts one column into the constant-current drivers MSB first,
 * pulses the latch, then steps the one-hot column select
 */
`timescale 1ns/10ps

module led_driver_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    col_if.receiver                      in,
    output logic                         drv_sclk,
    output logic                         drv_lat,
    output logic [pov_pkg::NUM_DRV-1:0]  drv_sin,
    output pov_pkg::col_mask_t           col_sel
);
    import pov_pkg::*;

    drv_state_e           state;
    column_t              sh;
    col_mask_t            mask_q;
    col_mask_t            col_ptr;
    col_mask_t            next_ptr;
    logic [DRV_CNT_W-1:0] bit_cnt;

    // Rotate the one-hot pointer
    assign next_ptr = {col_ptr[NUM_COLS-2:0], col_ptr[NUM_COLS-1]};

    // Each driver sees the MSB of its own word
    always_comb begin
        for (int k = 0; k < NUM_DRV; k++) begin
            drv_sin[k] = sh[k*DRV_BITS + DRV_BITS - 1];
        end
    end

    // Column capture, then shift each word at the end of the SCLK high half
    always_ff @(posedge clk) begin
        if (state == IDLE && in.valid) begin
            sh     <= in.data;
            mask_q <= in.mask;
        end else if (state == SHIFT && drv_sclk) begin
            for (int k = 0; k < NUM_DRV; k++) begin
                sh[k*DRV_BITS +: DRV_BITS] <= {sh[k*DRV_BITS +: DRV_BITS-1], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            drv_sclk  <= 1'b0;
            drv_lat   <= 1'b0;
            // Parked on the last line so the first column lands on line 0
            col_ptr   <= {1'b1, {(NUM_COLS-1){1'b0}}};
            col_sel   <= '0;
            in.credit <= 1'b0;
        end else begin
            in.credit <= 1'b0;
            case (state)
                IDLE: begin
                    if (in.valid) begin
                        state   <= SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SHIFT: begin
                    // Low half then high half per bit
                    drv_sclk <= ~drv_sclk;
                    if (drv_sclk) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == DRV_CNT_W'(DRV_BITS - 1)) begin
                            state <= LATCH;
                        end
                    end
                end
                LATCH: begin
                    // Idle cycle, latch cycle, then advance
                    drv_lat <= ~drv_lat;
                    if (drv_lat) begin
                        col_ptr   <= next_ptr;
                        col_sel   <= next_ptr & mask_q;
                        in.credit <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Latch only once the shift clock has gone quiet
    a_lat_sclk_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(drv_lat && drv_sclk)
    ) else $error("drv_lat overlaps drv_sclk");

    // Never more than one column line driven
    a_col_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(col_sel)
    ) else $error("col_sel not one-hot");

endmodule

/* pov_top.sv */
/*
 * POV LED column engine top level
 * SPI command receiver feeding a column buffer, which feeds
 * the LED driver controller, all over credit-based column links
 */
`timescale 1ns/10ps

module pov_top (
    input  logic                         clk,
    input  logic                         arst_n,
    // SPI slave
    input  logic                         spi_cs_n,
    input  logic                         spi_sclk,
    input  logic                         spi_mosi,
    output logic                         spi_miso,
    // LED drivers and column mux
    output logic                         drv_sclk,
    output logic [pov_pkg::NUM_DRV-1:0]  drv_sin,
    output logic                         drv_lat,
    output pov_pkg::col_mask_t           col_sel
);

    // Producer to buffer, buffer to consumer
    col_if link_in ();
    col_if link_out ();

    spi_cmd_rx u_spi_cmd_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .out      (link_in.sender)
    );

    column_fifo u_column_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (link_in.receiver),
        .out    (link_out.sender)
    );

    led_driver_ctrl u_led_driver_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .in       (link_out.receiver),
        .drv_sclk (drv_sclk),
        .drv_lat  (drv_lat),
        .drv_sin  (drv_sin),
        .col_sel  (col_sel)
    );

endmodule

/* tb_clkgen.sv */
/*
 * Testbench clock and reset generator
 * Free-running clk, arst_n held low for the first reset cycles
 */
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        #(PERIOD_NS * RESET_CYCLES);
        arst_n = 1'b1;
    end

endmodule

/* tb_pov_top.sv */
/*
 * POV LED column engine testbench
 * Random SPI command frames from an LCG, a reference model of the
 * column queue, mask, drop count and credits, and a monitor that
 * rebuilds each column from drv_sin and checks latch and col_sel
 */
`timescale 1ns/10ps

module tb_pov_top;
    import pov_pkg::*;

    localparam int CLK_NS     = 4;
    // clk cycles per SCLK half period, SCLK at clk/8
    localparam int SCLK_HALF  = 4;
    localparam int N_ORDER    = 8;
    localparam int N_IGNORE   = 6;
    localparam int N_BURST    = FIFO_DEPTH + 3;
    localparam int N_MIX      = 16;
    localparam int NUM_FRAMES = 2 * N_ORDER + N_IGNORE + N_BURST + N_MIX + 2;
    localparam int FRAME_CYC  = (COL_BYTES + 2) * 16 * SCLK_HALF + 100;
    localparam int DRAIN_CYC  = 40 * (FIFO_DEPTH + 2);
    localparam int TIMEOUT_NS = (NUM_FRAMES * FRAME_CYC + DRAIN_CYC + 200) * CLK_NS;

    logic               clk;
    logic               arst_n;
    logic               spi_cs_n;
    logic               spi_sclk;
    logic               spi_mosi;
    logic               spi_miso;
    logic               drv_sclk;
    logic               drv_lat;
    logic [NUM_DRV-1:0] drv_sin;
    col_mask_t          col_sel;

    // Reference model
    logic [31:0] lcg_state;
    column_t     exp_data_q [$];
    col_mask_t   exp_mask_q [$];
    col_mask_t   cur_mask;
    drop_cnt_t   exp_drops;
    int          model_credits;
    int          errors;
    int          checks;

    // Output monitor
    logic [DRV_BITS-1:0] got_word [NUM_DRV];
    int                  sclk_pulses;
    int                  since_sclk;
    logic                sclk_prev;
    logic                sel_due;
    col_mask_t           exp_ptr;
    col_mask_t           exp_sel;

    tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    pov_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .drv_sclk (drv_sclk),
        .drv_sin  (drv_sin),
        .drv_lat  (drv_lat),
        .col_sel  (col_sel)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'({9'd0, r[30:8]}) % (hi - lo + 1);
    endfunction

    task automatic check_val(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Mode 0, MOSI set while SCLK low, MISO taken at the rising edge
    task automatic spi_shift(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_mosi = tx[i];
            repeat (SCLK_HALF) @(negedge clk);
            spi_sclk = 1'b1;
            rx = {rx[6:0], spi_miso};
            repeat (SCLK_HALF) @(negedge clk);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic cs_begin();
        @(negedge clk);
        spi_cs_n = 1'b0;
        repeat (SCLK_HALF) @(negedge clk);
    endtask

    task automatic cs_end(input int gap);
        repeat (SCLK_HALF) @(negedge clk);
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic write_column(input int gap);
        column_t     col;
        logic [31:0] r;
        logic [7:0]  rx;
        for (int b = 0; b < COL_BYTES; b++) begin
            r = next_rand();
            col[b*8 +: 8] = r[23:16];
        end
        cs_begin();
        spi_shift(OP_WRITE_COL, 8, rx);
        // Top byte goes first
        for (int b = COL_BYTES - 1; b >= 0; b--) begin
            spi_shift(col[b*8 +: 8], 8, rx);
        end
        // Column complete, taken only against a held credit
        if (model_credits > 0) begin
            exp_data_q.push_back(col);
            exp_mask_q.push_back(cur_mask);
            model_credits--;
        end else begin
            exp_drops++;
        end
        cs_end(gap);
    endtask

    task automatic set_mask(input int gap);
        logic [31:0] r;
        logic [7:0]  rx;
        r = next_rand();
        cs_begin();
        spi_shift(OP_SET_MASK, 8, rx);
        spi_shift(r[15:8], 8, rx);
        cur_mask = r[15:8];
        // Trailing byte is ignored by the decoder
        if (r[20]) begin
            spi_shift(r[31:24], 8, rx);
        end
        cs_end(gap);
    endtask

    task automatic read_drops(input int gap);
        drop_cnt_t  snap;
        logic [7:0] rx;
        cs_begin();
        spi_shift(OP_READ_DROPS, 8, rx);
        snap = exp_drops;
        spi_shift(8'h00, 8, rx);
        check_val("drop count readback", rx, snap);
        cs_end(gap);
    endtask

    task automatic unknown_frame(input int gap);
        logic [7:0] op;
        logic [7:0] rx;
        int         extra;
        op = 8'(4 + rand_range(0, 251));
        extra = rand_range(0, 3);
        cs_begin();
        spi_shift(op, 8, rx);
        for (int i = 0; i < extra; i++) begin
            spi_shift(8'(rand_range(0, 255)), 8, rx);
        end
        cs_end(gap);
    endtask

    // CS rises before the last payload byte completes
    task automatic short_column(input int gap);
        int         nfull;
        int         nbits;
        logic [7:0] rx;
        nfull = rand_range(0, COL_BYTES - 1);
        nbits = rand_range(0, 7);
        cs_begin();
        spi_shift(OP_WRITE_COL, 8, rx);
        for (int i = 0; i < nfull; i++) begin
            spi_shift(8'(rand_range(0, 255)), 8, rx);
        end
        spi_shift(8'(rand_range(0, 255)), nbits, rx);
        cs_end(gap);
    endtask

    task automatic latch_seen();
        column_t   got;
        col_mask_t m;
        check_val("drv_sclk pulses before latch", sclk_pulses, DRV_BITS);
        check_val("idle cycles before latch", since_sclk, 1);
        for (int k = 0; k < NUM_DRV; k++) begin
            got[k*DRV_BITS +: DRV_BITS] = got_word[k];
        end
        if (exp_data_q.size() == 0) begin
            $display("Latch at %0t with no column outstanding in the model", $time);
            errors++;
        end else begin
            check_val("column data", got, exp_data_q.pop_front());
            m = exp_mask_q.pop_front();
            exp_ptr = {exp_ptr[NUM_COLS-2:0], exp_ptr[NUM_COLS-1]};
            exp_sel = exp_ptr & m;
            sel_due = 1'b1;
        end
        sclk_pulses = 0;
        model_credits++;
    endtask

    // Sampled on the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (arst_n) begin
            if (sel_due) begin
                check_val("col_sel after latch", col_sel, exp_sel);
                sel_due = 1'b0;
            end
            if (drv_sclk && !sclk_prev) begin
                for (int k = 0; k < NUM_DRV; k++) begin
                    got_word[k] = {got_word[k][DRV_BITS-2:0], drv_sin[k]};
                end
                sclk_pulses++;
            end
            if (drv_lat) begin
                latch_seen();
            end
            if (drv_sclk) begin
                since_sclk = 0;
            end else begin
                since_sclk++;
            end
            sclk_prev = drv_sclk;
        end
    end

    // Watchdog sized from frame count, frame length and drain time
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        int waited;
        spi_cs_n      = 1'b1;
        spi_sclk      = 1'b0;
        spi_mosi      = 1'b0;
        lcg_state     = 32'h1708;
        cur_mask      = '1;
        exp_drops     = '0;
        // Buffer slots plus the driver shift register
        model_credits = FIFO_DEPTH + 1;
        errors        = 0;
        checks        = 0;
        sclk_pulses   = 0;
        since_sclk    = 100;
        sclk_prev     = 1'b0;
        sel_due       = 1'b0;
        exp_ptr       = {1'b1, {(NUM_COLS-1){1'b0}}};
        exp_sel       = '0;

        @(posedge arst_n);
        @(negedge clk);
        check_val("drv_sclk after reset", drv_sclk, 0);
        check_val("drv_lat after reset", drv_lat, 0);
        check_val("col_sel after reset", col_sel, 0);
        check_val("spi_miso after reset", spi_miso, 0);

        // Spaced columns with occasional mask changes
        for (int i = 0; i < N_ORDER; i++) begin
            if (rand_range(0, 2) == 0) begin
                set_mask(rand_range(8, 20));
            end
            write_column(rand_range(40, 100));
        end

        // Frames that must leave no trace
        for (int i = 0; i < N_IGNORE; i++) begin
            if (i % 2 == 0) begin
                unknown_frame(rand_range(8, 20));
            end else begin
                short_column(rand_range(8, 20));
            end
        end
        read_drops(20);

        // Back-to-back burst against the credit limit
        for (int i = 0; i < N_BURST; i++) begin
            write_column(4);
        end
        read_drops(20);

        // Random mix of every frame type
        for (int i = 0; i < N_MIX; i++) begin
            case (rand_range(0, 7))
                0, 1, 2, 3: write_column(rand_range(4, 100));
                4:          set_mask(rand_range(4, 40));
                5:          read_drops(rand_range(4, 40));
                6:          unknown_frame(rand_range(4, 40));
                default:    short_column(rand_range(4, 40));
            endcase
        end

        // Let the buffer and the shift register empty out
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_CYC) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("Drain incomplete: %0d columns never reached the LED drivers",
                     exp_data_q.size());
            errors++;
        end
        repeat (8) @(negedge clk);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
pov_pkg.sv
col_if.sv
spi_cmd_rx.sv
column_fifo.sv
led_driver_ctrl.sv
pov_top.sv
tb_clkgen.sv
tb_pov_top.sv

/* Makefile */
# Verilator build and run for the POV LED column engine

VERILATOR ?= verilator
TOP       ?= tb_pov_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
